/* Makefile */
VERILATOR  ?= verilator
TOP        ?= alu_core_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --timescale 1ns/10ps -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/10ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* logic/alu.sv */
`timescale 1ns/10ps

module alu (
    input  alu_pkg::alu_op_t           op,
    input  logic [alu_pkg::DATA_W-1:0] a,
    input  logic [alu_pkg::DATA_W-1:0] b,
    input  logic [alu_pkg::DATA_W-1:0] imm,
    input  logic                       carry_in,
    output logic [alu_pkg::DATA_W-1:0] value,
    output alu_pkg::alu_flags_t        flags,
    output logic                       write
);
    import alu_pkg::*;

    logic [DATA_W:0]          ext_a;
    logic [DATA_W:0]          ext_b;
    logic [DATA_W:0]          ext_c;
    logic [DATA_W:0]          ext_one;
    logic [DATA_W:0]          ext_r;
    logic [DATA_W-1:0]        prod_u;
    logic signed [DATA_W-1:0] prod_s;
    logic                     over_flag;

    // the extra top bit of the 33-bit result carries out of the operation.
    always_comb begin
        ext_a   = {1'b0, a};
        ext_b   = {1'b0, b};
        ext_c   = {{DATA_W{1'b0}}, carry_in};
        ext_one = {{DATA_W{1'b0}}, 1'b1};
        prod_u  = {16'h0, a[15:0]} * {16'h0, b[15:0]};
        prod_s  = $signed({{16{a[15]}}, a[15:0]}) * $signed({{16{b[15]}}, b[15:0]});
        ext_r   = '0;
        write   = 1'b1;

        case (op)
            ADD:         ext_r = ext_a + ext_b;
            ADDC:        ext_r = ext_a + ext_b + ext_c;
            SUB:         ext_r = ext_a - ext_b;
            SUBC:        ext_r = ext_a - ext_b - ext_c;
            AND:         ext_r = ext_a & ext_b;
            OR:          ext_r = ext_a | ext_b;
            XOR:         ext_r = ext_a ^ ext_b;
            COMP: begin
                ext_r = ext_a - ext_b;
                write = 1'b0;
            end
            BIT: begin
                ext_r = ext_a & ext_b;
                write = 1'b0;
            end
            MULU:        ext_r = {1'b0, prod_u};
            // the signed product is sign extended into the carry bit.
            MULS:        ext_r = {prod_s[DATA_W-1], prod_s};
            INC:         ext_r = ext_a + ext_one;
            DEC:         ext_r = ext_a - ext_one;
            NOT:         ext_r = ~ext_a;
            LOGIC_LEFT:  ext_r = ext_a << 1;
            // right shifts put the bit shifted out into carry.
            LOGIC_RIGHT: ext_r = {a[0], 1'b0, a[DATA_W-1:1]};
            ARITH_LEFT:  ext_r = {a, 1'b0};
            ARITH_RIGHT: ext_r = {a[0], a[DATA_W-1], a[DATA_W-1:1]};
            NEG:         ext_r = ~ext_a + ext_one;
            SWAP:        ext_r = {1'b0, a[15:0], a[DATA_W-1:16]};
            TEST: begin
                ext_r = ext_a;
                write = 1'b0;
            end
            SIGN_EXT_B:  ext_r = {1'b0, {(DATA_W - 8){a[7]}}, a[7:0]};
            SIGN_EXT_W:  ext_r = {1'b0, {(DATA_W - 16){a[15]}}, a[15:0]};
            LOADI:       ext_r = {1'b0, imm};
            default:     ext_r = '0;
        endcase
    end

    always_comb begin
        case (op)
            // an add overflows when the result sign differs from both operand signs.
            ADD, ADDC: begin
                over_flag = (b[DATA_W-1] != ext_r[DATA_W-1]) &&
                            (a[DATA_W-1] != ext_r[DATA_W-1]);
            end
            // a subtract overflows when the result takes the sign of b against a.
            SUB, SUBC: begin
                over_flag = (b[DATA_W-1] == ext_r[DATA_W-1]) &&
                            (a[DATA_W-1] != ext_r[DATA_W-1]);
            end
            ARITH_LEFT: begin
                over_flag = (a[DATA_W-1] != ext_r[DATA_W-1]);
            end
            default: begin
                over_flag = 1'b0;
            end
        endcase
    end

    // compare-style opcodes leave the destination alone and pass a through.
    assign value = write ? ext_r[DATA_W-1:0] : a;

    assign flags.carry = ext_r[DATA_W];
    assign flags.zero  = (ext_r[DATA_W-1:0] == '0);
    assign flags.neg   = ext_r[DATA_W-1];
    assign flags.over  = over_flag;

endmodule

/* logic/alu_core_top.sv */
`timescale 1ns/10ps

module alu_core_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  alu_pkg::alu_cmd_t cmd,
    output logic              cmd_credit,
    output logic              res_valid,
    output alu_pkg::alu_res_t res,
    input  logic              res_credit
);
    import alu_pkg::*;

    logic              q_valid;
    alu_cmd_t          q_cmd;
    logic              q_pop;
    logic [REG_AW-1:0] rd_addr_a;
    logic [REG_AW-1:0] rd_addr_b;
    logic [DATA_W-1:0] rd_data_a;
    logic [DATA_W-1:0] rd_data_b;
    alu_op_t           op;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] imm;
    logic              carry;
    logic [DATA_W-1:0] alu_value;
    alu_flags_t        alu_flags;
    logic              alu_write;
    logic              wr_en;
    logic [REG_AW-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;

    command_queue command_queue_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .q_pop      (q_pop)
    );

    exec_unit exec_unit_i (
        .clk        (clk),
        .rst        (rst),
        .q_valid    (q_valid),
        .q_cmd      (q_cmd),
        .q_pop      (q_pop),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .op         (op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .imm        (imm),
        .carry      (carry),
        .alu_value  (alu_value),
        .alu_flags  (alu_flags),
        .alu_write  (alu_write),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .res_credit (res_credit),
        .res_valid  (res_valid),
        .res        (res)
    );

    register_file register_file_i (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu alu_i (
        .op       (op),
        .a        (operand_a),
        .b        (operand_b),
        .imm      (imm),
        .carry_in (carry),
        .value    (alu_value),
        .flags    (alu_flags),
        .write    (alu_write)
    );

endmodule

/* logic/alu_pkg.sv */
package alu_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_AW      = 4;
    localparam int NUM_REGS    = 16;
    localparam int CMD_DEPTH   = 4;
    localparam int RES_CREDITS = 2;

    // pointer and counter widths derived from the depths above.
    localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);
    localparam int RES_CNT_W = $clog2(RES_CREDITS + 1);

    // bit 4 of the code separates the one-operand group from the two-operand group.
    typedef enum logic [4:0] {
        ADD         = 5'h00,
        ADDC        = 5'h01,
        SUB         = 5'h02,
        SUBC        = 5'h03,
        AND         = 5'h04,
        OR          = 5'h05,
        XOR         = 5'h06,
        COMP        = 5'h07,
        BIT         = 5'h08,
        MULU        = 5'h09,
        MULS        = 5'h0a,
        INC         = 5'h10,
        DEC         = 5'h11,
        NOT         = 5'h12,
        LOGIC_LEFT  = 5'h13,
        LOGIC_RIGHT = 5'h14,
        ARITH_LEFT  = 5'h15,
        ARITH_RIGHT = 5'h16,
        NEG         = 5'h17,
        SWAP        = 5'h18,
        TEST        = 5'h19,
        SIGN_EXT_B  = 5'h1a,
        SIGN_EXT_W  = 5'h1b,
        LOADI       = 5'h1f
    } alu_op_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic neg;
        logic over;
    } alu_flags_t;

    // one command word as it travels over the input link.
    typedef struct packed {
        alu_op_t           op;
        logic [REG_AW-1:0] dst;
        logic [REG_AW-1:0] src_a;
        logic [REG_AW-1:0] src_b;
        logic [DATA_W-1:0] imm;
    } alu_cmd_t;

    // written is set when the register file was updated by the command.
    typedef struct packed {
        logic [REG_AW-1:0] dst;
        logic [DATA_W-1:0] value;
        alu_flags_t        flags;
        logic              written;
    } alu_res_t;

endpackage

/* logic/command_queue.sv */
`timescale 1ns/10ps

module command_queue (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  alu_pkg::alu_cmd_t cmd,
    output logic              cmd_credit,
    output logic              q_valid,
    output alu_pkg::alu_cmd_t q_cmd,
    input  logic              q_pop
);
    import alu_pkg::*;

    alu_cmd_t             mem [CMD_DEPTH];
    logic [CMD_PTR_W-1:0] wr_ptr;
    logic [CMD_PTR_W-1:0] rd_ptr;
    logic [CMD_CNT_W-1:0] count;

    assign q_valid = (count != '0);
    assign q_cmd   = mem[rd_ptr];

    // the sender never pushes without a credit, so there is no full check.
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= (rd_ptr == CMD_PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // each freed entry goes back to the sender as one credit.
            cmd_credit <= q_pop;
        end
    end

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       q_valid,
    input  alu_pkg::alu_cmd_t          q_cmd,
    output logic                       q_pop,
    output logic [alu_pkg::REG_AW-1:0] rd_addr_a,
    output logic [alu_pkg::REG_AW-1:0] rd_addr_b,
    input  logic [alu_pkg::DATA_W-1:0] rd_data_a,
    input  logic [alu_pkg::DATA_W-1:0] rd_data_b,
    output alu_pkg::alu_op_t           op,
    output logic [alu_pkg::DATA_W-1:0] operand_a,
    output logic [alu_pkg::DATA_W-1:0] operand_b,
    output logic [alu_pkg::DATA_W-1:0] imm,
    output logic                       carry,
    input  logic [alu_pkg::DATA_W-1:0] alu_value,
    input  alu_pkg::alu_flags_t        alu_flags,
    input  logic                       alu_write,
    output logic                       wr_en,
    output logic [alu_pkg::REG_AW-1:0] wr_addr,
    output logic [alu_pkg::DATA_W-1:0] wr_data,
    input  logic                       res_credit,
    output logic                       res_valid,
    output alu_pkg::alu_res_t          res
);
    import alu_pkg::*;

    logic [RES_CNT_W-1:0] res_cnt;
    alu_flags_t           flags_q;
    logic                 issue;

    // a command issues only when the consumer has room for its result.
    assign issue = q_valid && (res_cnt != '0);
    assign q_pop = issue;

    assign rd_addr_a = q_cmd.src_a;
    assign rd_addr_b = q_cmd.src_b;
    assign op        = q_cmd.op;
    assign operand_a = rd_data_a;
    assign operand_b = rd_data_b;
    assign imm       = q_cmd.imm;
    assign carry     = flags_q.carry;

    assign wr_en   = issue && alu_write;
    assign wr_addr = q_cmd.dst;
    assign wr_data = alu_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_cnt   <= RES_CNT_W'(RES_CREDITS);
            flags_q   <= '0;
            res_valid <= 1'b0;
        end else begin
            case ({issue, res_credit})
                2'b10:   res_cnt <= res_cnt - 1'b1;
                2'b01:   res_cnt <= res_cnt + 1'b1;
                default: res_cnt <= res_cnt;
            endcase
            if (issue) begin
                flags_q <= alu_flags;
            end
            res_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            res.dst     <= q_cmd.dst;
            res.value   <= alu_value;
            res.flags   <= alu_flags;
            res.written <= alu_write;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [alu_pkg::REG_AW-1:0] rd_addr_a,
    input  logic [alu_pkg::REG_AW-1:0] rd_addr_b,
    output logic [alu_pkg::DATA_W-1:0] rd_data_a,
    output logic [alu_pkg::DATA_W-1:0] rd_data_b,
    input  logic                       wr_en,
    input  logic [alu_pkg::REG_AW-1:0] wr_addr,
    input  logic [alu_pkg::DATA_W-1:0] wr_data
);
    import alu_pkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // reads are combinational so a write is visible from the next cycle on.
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* tb.f */
logic/alu_pkg.sv
logic/alu.sv
logic/register_file.sv
logic/command_queue.sv
logic/exec_unit.sv
logic/alu_core_top.sv
verification/tb_clock_gen.sv
verification/alu_core_tb.sv

/* verification/alu_core_tb.sv */
`timescale 1ns/10ps

module alu_core_tb;
    import alu_pkg::*;

    localparam int N_LOAD   = 32;
    localparam int N_TWO    = 48;
    localparam int N_ONE    = 46;
    localparam int N_BURST  = 60;
    localparam int N_CHAIN  = 20;
    localparam int NUM_CMDS = N_LOAD + N_TWO + N_ONE + N_BURST + N_CHAIN;
    localparam alu_op_t CHAIN_OPS [8] = '{ADD, ADDC, SUB, SUBC, XOR, INC, NEG, LOGIC_LEFT};

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    alu_cmd_t    cmd;
    logic        cmd_credit;
    logic        res_valid;
    alu_res_t    res;
    logic        res_credit;

    logic [15:0]       lfsr_state;
    logic [DATA_W-1:0] shadow [NUM_REGS];
    logic              shadow_carry;
    alu_res_t          exp_q [$];
    int                credit_delays [$];
    int                send_credits;
    int                cmds_sent;
    int                cmd_pulses;
    int                res_seen;
    int                returned;

    tb_clock_gen tb_clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    alu_core_top alu_core_top_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    // the galois lfsr uses taps 16, 14, 13 and 11 and steps once per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // r0 stays zero because random commands never target it.
    function automatic logic [REG_AW-1:0] rand_dst();
        logic [31:0] v;
        v = 32'd1 + rand_bits(5) % 32'd15;
        return REG_AW'(v);
    endfunction

    function automatic alu_res_t alu_model(input alu_cmd_t c, input logic [DATA_W-1:0] a,
                                           input logic [DATA_W-1:0] b, input logic cin);
        logic [DATA_W:0]          r;
        logic                     wr;
        logic                     ovf;
        logic [DATA_W-1:0]        pu;
        logic signed [DATA_W-1:0] ps;
        alu_res_t                 e;
        wr  = 1'b1;
        ovf = 1'b0;
        pu  = 32'(a[15:0]) * 32'(b[15:0]);
        ps  = 32'($signed(a[15:0])) * 32'($signed(b[15:0]));
        case (c.op)
            ADD, ADDC:   r = {1'b0, a} + {1'b0, b} + {32'h0, cin & (c.op == ADDC)};
            SUB, SUBC:   r = {1'b0, a} - {1'b0, b} - {32'h0, cin & (c.op == SUBC)};
            AND, BIT:    r = {1'b0, a & b};
            OR:          r = {1'b0, a | b};
            XOR:         r = {1'b0, a ^ b};
            COMP:        r = {1'b0, a} - {1'b0, b};
            MULU:        r = {1'b0, pu};
            MULS:        r = {ps[31], ps};
            INC:         r = {1'b0, a} + 33'd1;
            DEC:         r = {1'b0, a} - 33'd1;
            NOT:         r = {1'b1, ~a};
            LOGIC_LEFT:  r = {a, 1'b0};
            LOGIC_RIGHT: r = {a[0], a >> 1};
            ARITH_LEFT:  r = {a, 1'b0};
            ARITH_RIGHT: r = {a[0], $signed(a) >>> 1};
            NEG:         r = {(a != '0), -a};
            SWAP:        r = {1'b0, a[15:0], a[31:16]};
            TEST:        r = {1'b0, a};
            SIGN_EXT_B:  r = {1'b0, 32'($signed(a[7:0]))};
            SIGN_EXT_W:  r = {1'b0, 32'($signed(a[15:0]))};
            LOADI:       r = {1'b0, c.imm};
            default:     r = '0;
        endcase
        if (c.op inside {COMP, BIT, TEST}) begin
            wr = 1'b0;
        end
        if (c.op inside {ADD, ADDC}) begin
            ovf = (r[31] != a[31]) && (r[31] != b[31]);
        end else if (c.op inside {SUB, SUBC}) begin
            ovf = (r[31] == b[31]) && (r[31] != a[31]);
        end else if (c.op == ARITH_LEFT) begin
            ovf = a[31] ^ a[30];
        end
        e.dst         = c.dst;
        e.value       = wr ? r[31:0] : a;
        e.flags.carry = r[32];
        e.flags.zero  = (r[31:0] == '0);
        e.flags.neg   = r[31];
        e.flags.over  = ovf;
        e.written     = wr;
        return e;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_result(input alu_res_t got, input alu_res_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] res got %h expected %h", got, exp));
        end
    endtask

    task automatic check_credits(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    // expected state moves forward when a command leaves, since results come back in order.
    task automatic send_cmd(input alu_op_t op, input logic [REG_AW-1:0] dst,
                            input logic [REG_AW-1:0] src_a, input logic [REG_AW-1:0] src_b,
                            input logic [DATA_W-1:0] imm);
        alu_cmd_t c;
        alu_res_t e;
        c.op    = op;
        c.dst   = dst;
        c.src_a = src_a;
        c.src_b = src_b;
        c.imm   = imm;
        while (send_credits == 0) begin
            @(posedge clk);
            #1;
        end
        e = alu_model(c, shadow[src_a], shadow[src_b], shadow_carry);
        exp_q.push_back(e);
        if (e.written) begin
            shadow[dst] = e.value;
        end
        shadow_carry = e.flags.carry;
        send_credits--;
        cmds_sent++;
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic send_random(input alu_op_t op);
        send_cmd(op, rand_dst(), REG_AW'(rand_bits(REG_AW)), REG_AW'(rand_bits(REG_AW)),
                 rand_bits(DATA_W));
    endtask

    task automatic send_no_write_and_readback(input alu_op_t op);
        logic [REG_AW-1:0] d;
        d = rand_dst();
        send_cmd(op, d, REG_AW'(rand_bits(REG_AW)), REG_AW'(rand_bits(REG_AW)), '0);
        send_cmd(OR, d, d, '0, '0);
    endtask

    // results are sampled at the edge that ends their valid cycle.
    always @(posedge clk) begin
        if (!rst) begin
            if (cmd_credit) begin
                cmd_pulses++;
                send_credits++;
            end
            if (res_valid) begin
                res_seen++;
                if (exp_q.size() == 0) begin
                    report_failure("a result arrived while no command was outstanding");
                end
                check_result(res, exp_q.pop_front());
                if (res_seen > returned + RES_CREDITS) begin
                    report_failure("the core sent more results than it held credits for");
                end
                credit_delays.push_back(int'(rand_bits(3)));
            end
            if (res_credit) begin
                returned++;
            end
        end
    end

    // the consumer returns one credit per result after a random wait.
    initial begin : consumer
        int delay;
        forever begin
            @(posedge clk);
            #1;
            res_credit = 1'b0;
            if (credit_delays.size() != 0) begin
                delay = credit_delays.pop_front();
                if (delay != 0) begin
                    repeat (delay) @(posedge clk);
                    #1;
                end
                res_credit = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_CMDS * 40 + 200) @(posedge clk);
        report_failure("timeout, results stopped arriving before all commands completed");
    end

    initial begin
        logic [REG_AW-1:0] prev;
        logic [REG_AW-1:0] d;
        logic [4:0]        sel;
        cmd_valid    = 1'b0;
        cmd          = '0;
        res_credit   = 1'b0;
        lfsr_state   = 16'd45905;
        shadow_carry = 1'b0;
        send_credits = CMD_DEPTH;
        cmds_sent    = 0;
        cmd_pulses   = 0;
        res_seen     = 0;
        returned     = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        @(negedge rst);

        send_cmd(LOADI, '0, '0, '0, '0);
        for (int i = 1; i < NUM_REGS; i++) begin
            send_cmd(LOADI, REG_AW'(i), '0, '0, rand_bits(DATA_W));
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            send_cmd(OR, REG_AW'(i), REG_AW'(i), '0, '0);
        end

        for (int i = 0; i < 40; i++) begin
            send_random(alu_op_t'(5'(rand_bits(4) % 32'd11)));
        end
        for (int i = 0; i < 8; i++) begin
            send_random(i[0] ? SUBC : ADDC);
        end

        for (int i = 0; i < 40; i++) begin
            send_random(alu_op_t'(5'h10 + 5'(rand_bits(4) % 32'd12)));
        end
        send_no_write_and_readback(COMP);
        send_no_write_and_readback(BIT);
        send_no_write_and_readback(TEST);

        // a long burst over both opcode groups and one unknown code, with credits held back.
        for (int i = 0; i < N_BURST; i++) begin
            sel = 5'(rand_bits(5) % 32'd24);
            if (sel < 5'd11) begin
                send_random(alu_op_t'(sel));
            end else begin
                send_random(alu_op_t'(5'h10 + (sel - 5'd11)));
            end
        end

        prev = rand_dst();
        for (int i = 0; i < N_CHAIN; i++) begin
            d = rand_dst();
            send_cmd(CHAIN_OPS[rand_bits(3)], d, prev, REG_AW'(rand_bits(REG_AW)),
                     rand_bits(DATA_W));
            prev = d;
        end

        while (exp_q.size() != 0 || returned != res_seen) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        check_credits("cmd_credit pulses", cmd_pulses, cmds_sent);
        check_credits("sender credits", send_credits, CMD_DEPTH);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam time HALF_PERIOD = 5ns;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk = ~clk;
        end
    end

    // reset is held over the first eight rising edges.
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule
